// File: hdl/asa_defs.svh
//****************************************
// ASA widths and PIO address map.
//****************************************
`ifndef ASA_DEFS_SVH
`define ASA_DEFS_SVH

// Descriptor fields.
`define ASA_RCI_NBITS       8
`define ASA_SCI_NBITS       10
`define ASA_FID_NBITS       11
`define ASA_LEN_NBITS       13
`define ASA_CLASS_NBITS     3
`define ASA_PRI_NBITS       2
`define ASA_META_NBITS      24
`define ASA_C2P_NBITS       16

// PIO word and address split.
`define ASA_PIO_NBITS       32
`define ASA_PIO_BLK_NBITS   4
`define ASA_PIO_OFS_NBITS   12

// Block selects, PIO address bits 15 to 12.
`define ASA_BLK_REG         4'h0
`define ASA_BLK_TABLE       4'h1

// Register word offsets.
`define ASA_REG_SUPERVISOR  12'h000
`define ASA_REG_CLASS2PRI   12'h001

`endif

// File: hdl/asa_meta_pkg.sv
//****************************************
// ASA descriptor metadata.
// One word read as unicast or type3.
//****************************************
`include "asa_defs.svh"

package asa_meta_pkg;

    // Len sits in the low bits of both views.
    typedef union packed {
        struct packed {
            logic [`ASA_RCI_NBITS-1:0]   rci;
            logic [`ASA_CLASS_NBITS-1:0] cls;
            logic [`ASA_LEN_NBITS-1:0]   len;
        } ucast;
        struct packed {
            logic [`ASA_FID_NBITS-1:0] fid;
            logic [`ASA_LEN_NBITS-1:0] len;
        } type3;
    } asa_meta_u;

endpackage

// File: hdl/asa_pio_pkg.sv
//****************************************
// ASA PIO bus word.
// Command view on start, data view after.
//****************************************
`include "asa_defs.svh"

package asa_pio_pkg;

    typedef union packed {
        struct packed {
            logic [15:0]                   rsvd;  // Not decoded.
            logic [`ASA_PIO_BLK_NBITS-1:0] blk;
            logic [`ASA_PIO_OFS_NBITS-1:0] ofs;
        } cmd;
        logic [`ASA_PIO_NBITS-1:0] data;
    } asa_pio_word_u;

endpackage

// File: hdl/asa_pio_bus.sv
//****************************************
// ASA PIO bus.
// Turns PIO commands into register bus
// strobes and merges the read responses.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa_pio_bus (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pio_start,
    input  logic                          pio_rw,
    input  asa_pio_pkg::asa_pio_word_u    pio_addr_wdata,
    output logic                          reg_wr,
    output logic                          reg_rd,
    output logic                          reg_bs,
    output logic                          mem_bs,
    output logic [`ASA_PIO_OFS_NBITS-1:0] reg_addr,
    output logic [`ASA_PIO_NBITS-1:0]     reg_din,
    input  logic                          reg_rvalid,
    input  logic [`ASA_PIO_NBITS-1:0]     reg_rdata,
    input  logic                          mem_rvalid,
    input  logic [`ASA_PIO_NBITS-1:0]     mem_rdata,
    output logic                          pio_ack,
    output logic                          pio_rvalid,
    output logic [`ASA_PIO_NBITS-1:0]     pio_rdata
);

    import asa_pio_pkg::*;

    logic          cmd_pend;
    logic          cmd_rw;
    asa_pio_word_u cmd_q;
    logic          ack_q;
    logic          nomap_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_pend <= 1'b0;
            ack_q    <= 1'b0;
            nomap_q  <= 1'b0;
        end else begin
            cmd_pend <= pio_start;
            ack_q    <= reg_wr;                          // Ack one cycle after data.
            nomap_q  <= reg_rd & ~reg_bs & ~mem_bs;      // No block answers this read.
        end
    end

    always_ff @(posedge clk) begin
        if (pio_start) begin
            cmd_rw <= pio_rw;
            cmd_q  <= pio_addr_wdata;
        end
    end

    // Strobe cycle: after start for reads, the data cycle for writes.
    assign reg_wr   = cmd_pend & ~cmd_rw;
    assign reg_rd   = cmd_pend & cmd_rw;
    assign reg_bs   = cmd_pend & (cmd_q.cmd.blk == `ASA_BLK_REG);
    assign mem_bs   = cmd_pend & (cmd_q.cmd.blk == `ASA_BLK_TABLE);
    assign reg_addr = cmd_q.cmd.ofs;
    assign reg_din  = pio_addr_wdata.data;

    assign pio_ack    = ack_q;
    assign pio_rvalid = reg_rvalid | mem_rvalid | nomap_q;
    assign pio_rdata  = reg_rdata | mem_rdata;           // Idle blocks return zero.

endmodule

// File: hdl/asa_reg.sv
//****************************************
// ASA configuration registers.
// Supervisor SCI and class-to-priority map.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          reg_bs,
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  logic [`ASA_PIO_OFS_NBITS-1:0] reg_addr,
    input  logic [`ASA_PIO_NBITS-1:0]     reg_din,
    output logic                          reg_rvalid,
    output logic [`ASA_PIO_NBITS-1:0]     reg_rdata,
    output logic [`ASA_SCI_NBITS-1:0]     supervisor_sci,
    output logic [`ASA_C2P_NBITS-1:0]     class2pri
);

    logic [`ASA_PIO_NBITS-1:0] rd_word;
    logic [`ASA_PIO_NBITS-1:0] rd_q;

    always_comb begin
        case (reg_addr)
            `ASA_REG_SUPERVISOR:
                rd_word = {{(`ASA_PIO_NBITS-`ASA_SCI_NBITS){1'b0}}, supervisor_sci};
            `ASA_REG_CLASS2PRI:
                rd_word = {{(`ASA_PIO_NBITS-`ASA_C2P_NBITS){1'b0}}, class2pri};
            default:
                rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            supervisor_sci <= '0;
            class2pri      <= '0;
            reg_rvalid     <= 1'b0;
        end else begin
            reg_rvalid <= reg_bs & reg_rd;
            if (reg_bs && reg_wr && reg_addr == `ASA_REG_SUPERVISOR)
                supervisor_sci <= reg_din[`ASA_SCI_NBITS-1:0];
            if (reg_bs && reg_wr && reg_addr == `ASA_REG_CLASS2PRI)
                class2pri <= reg_din[`ASA_C2P_NBITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reg_bs & reg_rd)
            rd_q <= rd_word;
    end

    assign reg_rdata = reg_rvalid ? rd_q : '0;

endmodule

// File: hdl/asa_rci2sci_table.sv
//****************************************
// ASA RCI-to-SCI table.
// Two copies so PIO reads never stall
// the descriptor lookup.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa_rci2sci_table (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_bs,
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  logic [`ASA_PIO_OFS_NBITS-1:0] reg_addr,
    input  logic [`ASA_PIO_NBITS-1:0]     reg_din,
    output logic                          mem_rvalid,
    output logic [`ASA_PIO_NBITS-1:0]     mem_rdata,
    input  logic                          lkp_rd,
    input  logic [`ASA_RCI_NBITS-1:0]     lkp_rci,
    output logic [`ASA_SCI_NBITS-1:0]     lkp_sci
);

    logic [`ASA_SCI_NBITS-1:0] pio_copy [0:(1<<`ASA_RCI_NBITS)-1];
    logic [`ASA_SCI_NBITS-1:0] lkp_copy [0:(1<<`ASA_RCI_NBITS)-1];
    logic [`ASA_SCI_NBITS-1:0] pio_sci;
    logic                      tbl_wr;
    logic                      tbl_rd;
    logic [`ASA_RCI_NBITS-1:0] tbl_addr;

    assign tbl_wr   = mem_bs & reg_wr;
    assign tbl_rd   = mem_bs & reg_rd;
    assign tbl_addr = reg_addr[`ASA_RCI_NBITS-1:0];   // Upper offset bits alias.

    always_ff @(posedge clk) begin
        if (tbl_wr)
            pio_copy[tbl_addr] <= reg_din[`ASA_SCI_NBITS-1:0];
        if (tbl_rd)
            pio_sci <= pio_copy[tbl_addr];
    end

    // Lookup copy, same writes.
    always_ff @(posedge clk) begin
        if (tbl_wr)
            lkp_copy[tbl_addr] <= reg_din[`ASA_SCI_NBITS-1:0];
        if (lkp_rd)
            lkp_sci <= lkp_copy[lkp_rci];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mem_rvalid <= 1'b0;
        else
            mem_rvalid <= tbl_rd;
    end

    assign mem_rdata = mem_rvalid ?
                       {{(`ASA_PIO_NBITS-`ASA_SCI_NBITS){1'b0}}, pio_sci} : '0;

endmodule

// File: hdl/asa_enq_build.sv
//****************************************
// ASA enqueue builder.
// Two-stage pipe from descriptor to TM
// enqueue and classifier request.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa_enq_build (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          piarb_asa_valid,
    input  logic                          piarb_asa_type3,
    input  asa_meta_pkg::asa_meta_u       piarb_asa_meta_data,
    output logic                          lkp_rd,
    output logic [`ASA_RCI_NBITS-1:0]     lkp_rci,
    input  logic [`ASA_SCI_NBITS-1:0]     lkp_sci,
    input  logic [`ASA_SCI_NBITS-1:0]     supervisor_sci,
    input  logic [`ASA_C2P_NBITS-1:0]     class2pri,
    output logic                          asa_classifier_valid,
    output logic [`ASA_FID_NBITS-1:0]     asa_classifier_fid,
    output logic                          asa_tm_enq_req,
    output logic [`ASA_SCI_NBITS-1:0]     asa_tm_enq_qid,
    output logic [`ASA_PRI_NBITS-1:0]     asa_tm_enq_pri,
    output logic [`ASA_LEN_NBITS-1:0]     asa_tm_enq_len
);

    logic                        s1_valid;
    logic                        s1_type3;
    logic [`ASA_CLASS_NBITS-1:0] s1_cls;
    logic [`ASA_FID_NBITS-1:0]   s1_fid;
    logic [`ASA_LEN_NBITS-1:0]   s1_len;
    logic [`ASA_SCI_NBITS-1:0]   s2_qid;
    logic [`ASA_PRI_NBITS-1:0]   s2_pri;

    // Only unicast descriptors go to the table.
    assign lkp_rd  = piarb_asa_valid & ~piarb_asa_type3;
    assign lkp_rci = piarb_asa_meta_data.ucast.rci;

    always_comb begin
        if (s1_type3) begin
            s2_qid = s1_fid[`ASA_SCI_NBITS-1:0];          // Low fid bits form the qid.
            s2_pri = {`ASA_PRI_NBITS{1'b1}};
        end else begin
            s2_qid = (lkp_sci == '0) ? supervisor_sci : lkp_sci;  // Empty entry.
            s2_pri = class2pri[s1_cls*`ASA_PRI_NBITS +: `ASA_PRI_NBITS];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid             <= 1'b0;
            s1_type3             <= 1'b0;
            asa_tm_enq_req       <= 1'b0;
            asa_classifier_valid <= 1'b0;
        end else begin
            s1_valid             <= piarb_asa_valid;
            s1_type3             <= piarb_asa_type3;
            asa_tm_enq_req       <= s1_valid;
            asa_classifier_valid <= s1_valid & s1_type3;
        end
    end

    always_ff @(posedge clk) begin
        s1_cls             <= piarb_asa_meta_data.ucast.cls;
        s1_fid             <= piarb_asa_meta_data.type3.fid;
        s1_len             <= piarb_asa_meta_data.ucast.len;  // Same bits in both views.
        asa_classifier_fid <= s1_fid;
        asa_tm_enq_qid     <= s2_qid;
        asa_tm_enq_pri     <= s2_pri;
        asa_tm_enq_len     <= s1_len;
    end

endmodule

// File: hdl/asa.sv
//****************************************
// ASA top level.
// Admission and service assignment.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pio_start,
    input  logic                          pio_rw,
    input  asa_pio_pkg::asa_pio_word_u    pio_addr_wdata,
    output logic                          pio_ack,
    output logic                          pio_rvalid,
    output logic [`ASA_PIO_NBITS-1:0]     pio_rdata,
    input  logic                          piarb_asa_valid,
    input  logic                          piarb_asa_type3,
    input  asa_meta_pkg::asa_meta_u       piarb_asa_meta_data,
    output logic                          asa_classifier_valid,
    output logic [`ASA_FID_NBITS-1:0]     asa_classifier_fid,
    output logic                          asa_tm_enq_req,
    output logic [`ASA_SCI_NBITS-1:0]     asa_tm_enq_qid,
    output logic [`ASA_PRI_NBITS-1:0]     asa_tm_enq_pri,
    output logic [`ASA_LEN_NBITS-1:0]     asa_tm_enq_len
);

    logic                          reg_wr;
    logic                          reg_rd;
    logic                          reg_bs;
    logic                          mem_bs;
    logic [`ASA_PIO_OFS_NBITS-1:0] reg_addr;
    logic [`ASA_PIO_NBITS-1:0]     reg_din;
    logic                          reg_rvalid;
    logic [`ASA_PIO_NBITS-1:0]     reg_rdata;
    logic                          mem_rvalid;
    logic [`ASA_PIO_NBITS-1:0]     mem_rdata;
    logic                          lkp_rd;
    logic [`ASA_RCI_NBITS-1:0]     lkp_rci;
    logic [`ASA_SCI_NBITS-1:0]     lkp_sci;
    logic [`ASA_SCI_NBITS-1:0]     supervisor_sci;
    logic [`ASA_C2P_NBITS-1:0]     class2pri;

    asa_pio_bus u_asa_pio_bus (
        .clk            (clk),
        .rst_n          (rst_n),
        .pio_start      (pio_start),
        .pio_rw         (pio_rw),
        .pio_addr_wdata (pio_addr_wdata),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_bs         (reg_bs),
        .mem_bs         (mem_bs),
        .reg_addr       (reg_addr),
        .reg_din        (reg_din),
        .reg_rvalid     (reg_rvalid),
        .reg_rdata      (reg_rdata),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata),
        .pio_ack        (pio_ack),
        .pio_rvalid     (pio_rvalid),
        .pio_rdata      (pio_rdata)
    );

    asa_reg u_asa_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_bs         (reg_bs),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_din        (reg_din),
        .reg_rvalid     (reg_rvalid),
        .reg_rdata      (reg_rdata),
        .supervisor_sci (supervisor_sci),
        .class2pri      (class2pri)
    );

    asa_rci2sci_table u_asa_rci2sci_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_bs     (mem_bs),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_din    (reg_din),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .lkp_rd     (lkp_rd),
        .lkp_rci    (lkp_rci),
        .lkp_sci    (lkp_sci)
    );

    asa_enq_build u_asa_enq_build (
        .clk                  (clk),
        .rst_n                (rst_n),
        .piarb_asa_valid      (piarb_asa_valid),
        .piarb_asa_type3      (piarb_asa_type3),
        .piarb_asa_meta_data  (piarb_asa_meta_data),
        .lkp_rd               (lkp_rd),
        .lkp_rci              (lkp_rci),
        .lkp_sci              (lkp_sci),
        .supervisor_sci       (supervisor_sci),
        .class2pri            (class2pri),
        .asa_classifier_valid (asa_classifier_valid),
        .asa_classifier_fid   (asa_classifier_fid),
        .asa_tm_enq_req       (asa_tm_enq_req),
        .asa_tm_enq_qid       (asa_tm_enq_qid),
        .asa_tm_enq_pri       (asa_tm_enq_pri),
        .asa_tm_enq_len       (asa_tm_enq_len)
    );

endmodule

// File: verification/asa_checker.sv
//****************************************
// ASA checker.
// Mirrors PIO writes, predicts PIO and
// enqueue outputs and counts mismatches.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module asa_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pio_start,
    input  logic                          pio_rw,
    input  asa_pio_pkg::asa_pio_word_u    pio_addr_wdata,
    input  logic                          pio_ack,
    input  logic                          pio_rvalid,
    input  logic [`ASA_PIO_NBITS-1:0]     pio_rdata,
    input  logic [`ASA_PIO_NBITS-1:0]     exp_rdata,
    input  logic                          piarb_asa_valid,
    input  logic                          piarb_asa_type3,
    input  asa_meta_pkg::asa_meta_u       piarb_asa_meta_data,
    input  logic                          asa_classifier_valid,
    input  logic [`ASA_FID_NBITS-1:0]     asa_classifier_fid,
    input  logic                          asa_tm_enq_req,
    input  logic [`ASA_SCI_NBITS-1:0]     asa_tm_enq_qid,
    input  logic [`ASA_PRI_NBITS-1:0]     asa_tm_enq_pri,
    input  logic [`ASA_LEN_NBITS-1:0]     asa_tm_enq_len,
    output int                            err_count
);

    import asa_meta_pkg::*;
    import asa_pio_pkg::*;

    logic [`ASA_SCI_NBITS-1:0]        tbl [0:(1<<`ASA_RCI_NBITS)-1];
    logic [`ASA_SCI_NBITS-1:0]        sup;
    logic [`ASA_C2P_NBITS-1:0]        c2p;
    logic                             wr_pend;
    asa_pio_word_u                    wr_cmd;
    logic [`ASA_SCI_NBITS-1:0]        entry;
    logic [`ASA_SCI_NBITS-1:0]        pred_qid;
    logic [`ASA_PRI_NBITS-1:0]        pred_pri;
    logic [1:0]                       ack_pipe;
    logic [1:0]                       rv_pipe;
    logic [1:0]                       enq_pipe;
    logic [1:0]                       t3_pipe;
    logic [1:0][`ASA_SCI_NBITS-1:0]   qid_pipe;
    logic [1:0][`ASA_PRI_NBITS-1:0]   pri_pipe;
    logic [1:0][`ASA_LEN_NBITS-1:0]   len_pipe;
    logic [1:0][`ASA_FID_NBITS-1:0]   fid_pipe;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    always_comb begin
        entry = tbl[piarb_asa_meta_data.ucast.rci];
        if (piarb_asa_type3) begin
            pred_qid = piarb_asa_meta_data.type3.fid[`ASA_SCI_NBITS-1:0];
            pred_pri = 2'd3;
        end else begin
            pred_qid = (entry != '0) ? entry : sup;  // Empty entry goes to the supervisor.
            pred_pri = 2'(c2p >> {piarb_asa_meta_data.ucast.cls, 1'b0});
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_count = 0;
            wr_pend   <= 1'b0;
            sup       <= '0;
            c2p       <= '0;
            ack_pipe  <= 2'b00;
            rv_pipe   <= 2'b00;
            enq_pipe  <= 2'b00;
            t3_pipe   <= 2'b00;
        end else begin
            compare_value("pio_ack", 32'(ack_pipe[1]), 32'(pio_ack));
            compare_value("pio_rvalid", 32'(rv_pipe[1]), 32'(pio_rvalid));
            if (rv_pipe[1])
                compare_value("pio_rdata", exp_rdata, pio_rdata);
            compare_value("asa_tm_enq_req", 32'(enq_pipe[1]), 32'(asa_tm_enq_req));
            compare_value("asa_classifier_valid", 32'(enq_pipe[1] & t3_pipe[1]),
                          32'(asa_classifier_valid));
            if (enq_pipe[1]) begin
                compare_value("asa_tm_enq_qid", 32'(qid_pipe[1]), 32'(asa_tm_enq_qid));
                compare_value("asa_tm_enq_pri", 32'(pri_pipe[1]), 32'(asa_tm_enq_pri));
                compare_value("asa_tm_enq_len", 32'(len_pipe[1]), 32'(asa_tm_enq_len));
            end
            if (enq_pipe[1] && t3_pipe[1])
                compare_value("asa_classifier_fid", 32'(fid_pipe[1]), 32'(asa_classifier_fid));

            // Write data follows the start cycle.
            wr_pend <= pio_start & ~pio_rw;
            if (pio_start)
                wr_cmd <= pio_addr_wdata;
            if (wr_pend && wr_cmd.cmd.blk == `ASA_BLK_REG) begin
                if (wr_cmd.cmd.ofs == `ASA_REG_SUPERVISOR)
                    sup <= pio_addr_wdata.data[`ASA_SCI_NBITS-1:0];
                if (wr_cmd.cmd.ofs == `ASA_REG_CLASS2PRI)
                    c2p <= pio_addr_wdata.data[`ASA_C2P_NBITS-1:0];
            end
            if (wr_pend && wr_cmd.cmd.blk == `ASA_BLK_TABLE)
                tbl[wr_cmd.cmd.ofs[`ASA_RCI_NBITS-1:0]] <= pio_addr_wdata.data[`ASA_SCI_NBITS-1:0];

            ack_pipe <= {ack_pipe[0], pio_start & ~pio_rw};
            rv_pipe  <= {rv_pipe[0], pio_start & pio_rw};
            enq_pipe <= {enq_pipe[0], piarb_asa_valid};
            t3_pipe  <= {t3_pipe[0], piarb_asa_valid & piarb_asa_type3};
            qid_pipe <= {qid_pipe[0], pred_qid};
            pri_pipe <= {pri_pipe[0], pred_pri};
            len_pipe <= {len_pipe[0], piarb_asa_meta_data.type3.len};
            fid_pipe <= {fid_pipe[0], piarb_asa_meta_data.type3.fid};
        end
    end

endmodule

// File: verification/tb_asa.sv
//****************************************
// ASA testbench.
// Programs the block over PIO, then sends
// descriptors from a stimulus table.
//****************************************
`timescale 1ns/1ns
`include "asa_defs.svh"

module tb_asa;

    import asa_meta_pkg::*;
    import asa_pio_pkg::*;

    localparam logic [1:0] kind_wr   = 2'd0;
    localparam logic [1:0] kind_rd   = 2'd1;
    localparam logic [1:0] kind_desc = 2'd2;

    typedef struct packed {
        logic [1:0]                kind;
        logic                      type3;
        logic [`ASA_PIO_NBITS-1:0] word;  // PIO address or descriptor.
        logic [`ASA_PIO_NBITS-1:0] data;  // Write data or expected read data.
    } step_t;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      pio_start;
    logic                      pio_rw;
    asa_pio_word_u             pio_addr_wdata;
    logic                      pio_ack;
    logic                      pio_rvalid;
    logic [`ASA_PIO_NBITS-1:0] pio_rdata;
    logic                      piarb_asa_valid;
    logic                      piarb_asa_type3;
    asa_meta_u                 piarb_asa_meta_data;
    logic                      asa_classifier_valid;
    logic [`ASA_FID_NBITS-1:0] asa_classifier_fid;
    logic                      asa_tm_enq_req;
    logic [`ASA_SCI_NBITS-1:0] asa_tm_enq_qid;
    logic [`ASA_PRI_NBITS-1:0] asa_tm_enq_pri;
    logic [`ASA_LEN_NBITS-1:0] asa_tm_enq_len;
    logic [`ASA_PIO_NBITS-1:0] exp_rdata;
    int                        err_count;
    int                        timeouts;
    int                        seed;
    step_t                     steps [$];

    always #20 clk = ~clk;

    asa dut_i (.*);

    asa_checker check_i (.*);

    function automatic logic [31:0] pio_word(input logic [3:0] blk, input logic [11:0] ofs);
        return {16'h0000, blk, ofs};
    endfunction

    // Never zero, depends on every RCI bit.
    function automatic logic [9:0] fill_sci(input logic [7:0] rci);
        return {rci, 2'b00} ^ 10'h155;
    endfunction

    function automatic logic [23:0] ucast_word(input logic [7:0] rci, input logic [2:0] cls,
                                               input logic [12:0] len);
        return {rci, cls, len};
    endfunction

    function automatic logic [23:0] type3_word(input logic [10:0] fid, input logic [12:0] len);
        return {fid, len};
    endfunction

    task automatic add_step(input logic [1:0] kind, input logic type3,
                            input logic [31:0] word, input logic [31:0] data);
        step_t s;
        s.kind  = kind;
        s.type3 = type3;
        s.word  = word;
        s.data  = data;
        steps.push_back(s);
    endtask

    task automatic run_pio(input logic rw, input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        pio_start      <= 1'b1;
        pio_rw         <= rw;
        pio_addr_wdata <= addr;
        exp_rdata      <= rw ? data : 32'h0;
        @(posedge clk);
        pio_start      <= 1'b0;
        pio_addr_wdata <= rw ? 32'h0 : data;  // Data cycle of a write.
        @(negedge clk);
        while (!(rw ? pio_rvalid : pio_ack) && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 10) begin
            $display("Timeout: no %s for the PIO command to address %h",
                     rw ? "read data" : "write ack", addr);
            timeouts++;
        end
        @(posedge clk);
        pio_addr_wdata <= 32'h0;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_desc(input logic type3, input logic [23:0] meta);
        @(posedge clk);
        piarb_asa_valid     <= 1'b1;
        piarb_asa_type3     <= type3;
        piarb_asa_meta_data <= meta;
    endtask

    // Ends a burst and waits until the last enqueue has left.
    task automatic drain_pipe();
        int waited;
        waited = 0;
        @(posedge clk);
        piarb_asa_valid     <= 1'b0;
        piarb_asa_type3     <= 1'b0;
        piarb_asa_meta_data <= '0;
        @(negedge clk);
        while (!asa_tm_enq_req && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 10) begin
            $display("Timeout: no enqueue request after a descriptor burst");
            timeouts++;
        end
        waited = 0;
        while (asa_tm_enq_req && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 10) begin
            $display("Timeout: enqueue requests did not stop after the burst");
            timeouts++;
        end
    endtask

    initial begin
        step_t       cur;
        int          i;
        int          n;
        logic [31:0] rnd;
        logic        last;
        rst_n               <= 1'b0;
        pio_start           <= 1'b0;
        pio_rw              <= 1'b0;
        pio_addr_wdata      <= '0;
        piarb_asa_valid     <= 1'b0;
        piarb_asa_type3     <= 1'b0;
        piarb_asa_meta_data <= '0;
        exp_rdata           <= '0;
        timeouts = 0;
        seed     = 32'h5871;

        add_step(kind_wr, 1'b0, pio_word(`ASA_BLK_REG, `ASA_REG_SUPERVISOR), 32'h0000_02a5);
        add_step(kind_wr, 1'b0, pio_word(`ASA_BLK_REG, `ASA_REG_CLASS2PRI), 32'h0000_1be4);
        for (n = 0; n < 256; n++)
            add_step(kind_wr, 1'b0, pio_word(`ASA_BLK_TABLE, {4'h0, 8'(n)}),
                     {22'h0, fill_sci(8'(n))});
        add_step(kind_wr, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h040), 32'h0);
        add_step(kind_wr, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h041), 32'h0);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_REG, `ASA_REG_SUPERVISOR), 32'h0000_02a5);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_REG, `ASA_REG_CLASS2PRI), 32'h0000_1be4);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h007), {22'h0, fill_sci(8'h07)});
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h040), 32'h0);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_REG, 12'h005), 32'h0);   // Unknown offset.
        add_step(kind_rd, 1'b0, pio_word(4'h2, 12'h000), 32'h0);            // Unmapped block.
        add_step(kind_desc, 1'b0, {8'h00, ucast_word(8'h07, 3'd2, 13'd100)}, 32'h0);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_REG, `ASA_REG_SUPERVISOR), 32'h0000_02a5);
        add_step(kind_desc, 1'b0, {8'h00, ucast_word(8'h40, 3'd5, 13'd1500)}, 32'h0);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h041), 32'h0);
        add_step(kind_desc, 1'b1, {8'h00, type3_word(11'h155, 13'd64)}, 32'h0);
        add_step(kind_rd, 1'b0, pio_word(`ASA_BLK_TABLE, 12'h0ff), {22'h0, fill_sci(8'hff)});
        for (n = 0; n < 24; n++) begin
            rnd = $random(seed);
            if (rnd[25:24] == 2'b11)
                add_step(kind_desc, 1'b1, {8'h00, type3_word({1'b0, rnd[9:0]}, rnd[23:11])},
                         32'h0);
            else
                add_step(kind_desc, 1'b0, {8'h00, ucast_word(rnd[7:0], rnd[10:8], rnd[23:11])},
                         32'h0);
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);  // Outputs stay idle here.

        for (i = 0; i < steps.size(); i++) begin
            cur = steps[i];
            if (cur.kind == kind_desc) begin
                send_desc(cur.type3, cur.word[23:0]);
                last = (i == steps.size() - 1) ? 1'b1 : (steps[i + 1].kind != kind_desc);
                if (last)
                    drain_pipe();
            end else begin
                run_pio(cur.kind == kind_rd, cur.word, cur.data);
            end
        end

        repeat (5) @(posedge clk);
        $display("Run complete: %0d value errors, %0d timeouts", err_count, timeouts);
        if (err_count == 0 && timeouts == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/asa_meta_pkg.sv
hdl/asa_pio_pkg.sv
hdl/asa_pio_bus.sv
hdl/asa_reg.sv
hdl/asa_rci2sci_table.sv
hdl/asa_enq_build.sv
hdl/asa.sv
verification/asa_checker.sv
verification/tb_asa.sv

// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing
TOP     = tb_asa
FLIST   = project.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST)) hdl/asa_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed."; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation did not finish."; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
